// File: src.f
source/mic_types_pkg.sv
source/mic_ucode_pkg.sv
source/mic_ctrl_if.sv
source/mic_word_decode.sv
source/mic_return_stack.sv
source/mic_addr_select.sv
source/mic_addr_latch.sv
source/mic_sequencer.sv
verification/mic_sequencer_checker.sv
verification/mic_clk_gen.sv
verification/mic_sequencer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the mic_sequencer testbench with Verilator, run it and scan the log.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=mic_sequencer_sim
log_file=sim.log

verilator --binary --timing --assert \
  -f src.f \
  --top-module mic_sequencer_tb \
  --Mdir "$build_dir" \
  -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
  echo "failure reported in $log_file"
  exit 1
fi

echo "no failure found in $log_file"
exit 0

// File: verification/mic_sequencer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mic_sequencer_tb;

  import mic_types_pkg::*;

  localparam int clk_period  = 40;  // ns, same as the clock generator.
  localparam int drive_delay = 5;   // inputs change this long after an edge.
  localparam int max_depth   = 4;   // calls the return stack can hold.
  localparam int rst_cycles  = 10;  // reset length, same as the clock generator.

  localparam int n_idle  = 8;                  // idle cycles after reset.
  localparam int n_seq   = 10;                 // plain sequential steps.
  localparam int n_wrap  = 5;                  // jump to 1FFE, then over the top.
  localparam int n_jump  = 12;                 // random jumps.
  localparam int n_nest  = max_depth;          // call depth of the nesting test.
  localparam int n_rep   = 6;                  // repeated steps.
  localparam int n_fault = 2 * max_depth + 6;  // steps of the fault test.
  localparam int n_rst   = rst_cycles + 1;     // reset inside the fault test.
  localparam int total_steps = n_idle + n_seq + n_wrap + n_jump + 3 * n_nest
                             + n_rep + n_fault + n_rst;

  localparam msel_t code_jump   = 2'd0;  // microword select codes.
  localparam msel_t code_return = 2'd1;
  localparam msel_t code_next   = 2'd2;
  localparam msel_t code_repeat = 2'd3;

  wire    sysclk;
  wire    sys_rst_n;
  logic   rst_req;
  logic   step;
  mword_t mword;
  jmp_t   jmp;
  maddr_t w;
  maddr_t iw;
  logic   stack_err;

  maddr_t m_w;          // expected fetch address.
  maddr_t m_iw;         // expected executing address.
  logic   m_err;        // expected fault flag.
  maddr_t m_stack[$];   // expected return stack, back is the top.
  int     errors;       // failed checks over the whole run.
  int     checks;       // checks done over the whole run.
  int     test_errs;    // failed checks of the running test.

  mic_clk_gen clk_gen_i (
    .rst_req   (rst_req),
    .sysclk    (sysclk),
    .sys_rst_n (sys_rst_n)
  );

  mic_sequencer mic_sequencer_i (
    .sysclk    (sysclk),
    .sys_rst_n (sys_rst_n),
    .step      (step),
    .mword     (mword),
    .jmp       (jmp),
    .w         (w),
    .iw        (iw),
    .stack_err (stack_err)
  );

  //////////////////////////////////////////////////////////////////////
  // checks and reference model.
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input maddr_t got, input maddr_t exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %s: got %h, expected %h at %0t ns", name, got, exp, $time);
      test_errs++;
    end
  endtask

  task automatic check_outputs();
    check_value("w", w, m_w);
    check_value("iw", iw, m_iw);
    check_value("stack_err", maddr_t'(stack_err), maddr_t'(m_err));
  endtask

  // one step of the sequencer as the address rules describe it.
  task automatic model_step(input mword_t mw, input jmp_t j);
    maddr_t jump_addr;
    maddr_t seq_addr;
    maddr_t new_w;
    jump_addr = {mw[12], mw[11:4], j};  // csbit 3..0 never reach the address.
    seq_addr  = m_w + maddr_t'(1);      // 13-bit wrap comes for free.
    new_w     = seq_addr;
    case (mw[15:14])
      code_jump: begin
        new_w = jump_addr;
        if (mw[13]) begin
          if (m_stack.size() < max_depth) begin
            m_stack.push_back(seq_addr);  // return lands after the call.
          end else begin
            m_err = 1'b1;                 // overflow, jump without a push.
          end
        end
      end
      code_return: begin
        if (m_stack.size() == 0) begin
          m_err = 1'b1;                   // underflow acts as next.
        end else begin
          new_w = m_stack.pop_back();
        end
      end
      code_next:   new_w = seq_addr;
      code_repeat: new_w = m_iw;
    endcase
    m_iw = m_w;
    m_w  = new_w;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers, entered drive_delay after an edge.
  //////////////////////////////////////////////////////////////////////

  task automatic step_once(input mword_t mw, input jmp_t j);
    step  = 1'b1;
    mword = mw;
    jmp   = j;
    model_step(mw, j);
    @(posedge sysclk);
    #drive_delay;
    step = 1'b0;
    check_outputs();  // registers settled well before the next edge.
  endtask

  task automatic idle_once();
    mword = mword_t'($urandom);  // any word, it must be ignored.
    jmp   = jmp_t'($urandom);
    @(posedge sysclk);
    #drive_delay;
    check_outputs();
  endtask

  // a second reset, after which the model starts over from zero.
  task automatic reset_again();
    rst_req = 1'b1;
    wait (sys_rst_n === 1'b0);
    rst_req = 1'b0;
    wait (sys_rst_n === 1'b1);
    @(posedge sysclk);
    #drive_delay;
    m_w   = '0;
    m_iw  = '0;
    m_err = 1'b0;
    m_stack.delete();
    check_outputs();  // reset state, flag cleared.
  endtask

  function automatic mword_t jump_word(input maddr_t target, input logic call);
    return {code_jump, call, target[12], target[11:4], 4'($urandom)};
  endfunction

  function automatic mword_t plain_word(input msel_t code);
    return {code, 14'($urandom)};
  endfunction

  task automatic jump_to(input maddr_t target, input logic call);
    step_once(jump_word(target, call), target[3:0]);  // dispatch bits fill the bottom.
  endtask

  task automatic finish_test(input string name);
    $display("test %s done with %0d errors", name, test_errs);
    errors    += test_errs;
    test_errs  = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests.
  //////////////////////////////////////////////////////////////////////

  task automatic reset_and_idle();
    check_outputs();  // reset state.
    repeat (n_idle) idle_once();
    finish_test("reset_idle");
  endtask

  task automatic sequential_run();
    repeat (n_seq) step_once(plain_word(code_next), jmp_t'($urandom));
    jump_to(13'h1ffe, 1'b0);
    repeat (n_wrap - 1) step_once(plain_word(code_next), jmp_t'($urandom));
    finish_test("sequential");
  endtask

  task automatic jump_dispatch();
    repeat (n_jump) jump_to(maddr_t'($urandom), 1'b0);
    finish_test("jump_dispatch");
  endtask

  task automatic call_nesting();
    repeat (n_nest) begin
      jump_to(maddr_t'($urandom), 1'b1);
      step_once(plain_word(code_next), jmp_t'($urandom));  // move off the target.
    end
    repeat (n_nest) step_once(plain_word(code_return), jmp_t'($urandom));
    finish_test("call_return");
  endtask

  task automatic repeat_step();
    repeat (n_rep) step_once(plain_word(code_repeat), jmp_t'($urandom));
    finish_test("repeat");
  endtask

  task automatic stack_faults();
    step_once(plain_word(code_return), jmp_t'($urandom));  // stack is empty here.
    repeat (2) step_once(plain_word(code_next), jmp_t'($urandom));
    reset_again();  // the overflow below has to raise the flag by itself.
    repeat (max_depth + 1) jump_to(maddr_t'($urandom), 1'b1);
    repeat (max_depth) step_once(plain_word(code_return), jmp_t'($urandom));
    repeat (2) step_once(plain_word(code_next), jmp_t'($urandom));
    finish_test("stack_fault");
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control.
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(33));  // one seed for the whole run.
    rst_req   = 1'b0;
    step      = 1'b0;
    mword     = '0;
    jmp       = '0;
    m_w       = '0;
    m_iw      = '0;
    m_err     = 1'b0;
    errors    = 0;
    checks    = 0;
    test_errs = 0;
    wait (sys_rst_n === 1'b1);
    @(posedge sysclk);
    #drive_delay;
    reset_and_idle();
    sequential_run();
    jump_dispatch();
    call_nesting();
    repeat_step();
    stack_faults();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // every step and idle cycle takes one clock, plus room for reset.
  initial begin
    #((total_steps + 100) * clk_period);
    $display("timeout: tests still running after %0d ns", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/mic_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module mic_clk_gen (
  input  wire  rst_req,    // rising edge starts another reset sequence.
  output logic sysclk,     // 40 ns system clock.
  output logic sys_rst_n   // synchronous reset, low at start.
);

  localparam int half_period = 20;  // half of the 40 ns period.
  localparam int rst_cycles  = 10;  // rising edges seen with reset low.
  localparam int rst_delay   = 5;   // release lags the edge like all stimulus.

  initial begin
    sysclk = 1'b0;
    forever #half_period sysclk = ~sysclk;
  end

  // holds reset low for rst_cycles edges and lets go between two edges.
  task automatic run_reset();
    sys_rst_n = 1'b0;
    repeat (rst_cycles) @(posedge sysclk);
    #rst_delay;
    sys_rst_n = 1'b1;  // released between edges, so no edge sees it change.
  endtask

  initial begin
    run_reset();
    forever begin
      @(posedge rst_req);
      run_reset();  // a later reset starts where the request was raised.
    end
  end

endmodule

`default_nettype wire

// File: verification/mic_sequencer_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mic_sequencer_checker (
  input wire                        sysclk,
  input wire                        sys_rst_n,
  input wire                        step,       // advance strobe.
  input wire mic_types_pkg::maddr_t w,          // fetch address.
  input wire mic_types_pkg::maddr_t iw,         // executing address.
  input wire                        stack_err   // sticky stack fault.
);

  //////////////////////////////////////////////////////////////////////
  // address pipe rules.
  //////////////////////////////////////////////////////////////////////

  // an edge without step leaves both registers alone.
  hold_without_step: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
      !step |=> ($stable(w) && $stable(iw))
  ) else $error("w or iw moved on an edge without step");

  // the fetched address becomes the executing one on every step.
  iw_follows_w: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
      step |=> (iw == $past(w))
  ) else $error("iw does not hold the fetch address of the previous step");

  //////////////////////////////////////////////////////////////////////
  // fault flag.
  //////////////////////////////////////////////////////////////////////

  // once set, only a reset clears it.
  err_is_sticky: assert property (
    @(posedge sysclk) disable iff (!sys_rst_n)
      stack_err |=> stack_err
  ) else $error("stack_err dropped while out of reset");

endmodule

bind mic_sequencer mic_sequencer_checker checker_i (
  .sysclk    (sysclk),
  .sys_rst_n (sys_rst_n),
  .step      (step),
  .w         (w),
  .iw        (iw),
  .stack_err (stack_err)
);

`default_nettype wire

// File: source/mic_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module mic_sequencer (
  input  wire                        sysclk,
  input  wire                        sys_rst_n,
  input  wire                        step,       // one-cycle advance strobe.
  input  wire mic_types_pkg::mword_t mword,      // microword at iw.
  input  wire mic_types_pkg::jmp_t   jmp,        // dispatch field.
  output mic_types_pkg::maddr_t      w,          // fetch address.
  output mic_types_pkg::maddr_t      iw,         // executing address.
  output logic                       stack_err   // sticky stack fault.
);

  mic_types_pkg::maddr_t rep;        // selected address for w.
  mic_types_pkg::maddr_t next_addr;  // w plus one.
  logic                  stack_empty;
  logic                  stack_full;

  mic_ctrl_if ctrl_if ();  // decoded control, decode to execute.

  //////////////////////////////////////////////////////////////////////
  // decode, execute and result stages.
  //////////////////////////////////////////////////////////////////////

  mic_word_decode word_decode_i (
    .mword       (mword),
    .step        (step),
    .stack_empty (stack_empty),
    .stack_full  (stack_full),
    .ctrl        (ctrl_if.decode_mp)
  );

  mic_addr_select addr_select_i (
    .sysclk      (sysclk),
    .sys_rst_n   (sys_rst_n),
    .ctrl        (ctrl_if.exec_mp),
    .jmp         (jmp),
    .next_addr   (next_addr),
    .iw          (iw),
    .rep         (rep),
    .stack_empty (stack_empty),
    .stack_full  (stack_full),
    .stack_err   (stack_err)
  );

  mic_addr_latch addr_latch_i (
    .sysclk    (sysclk),
    .sys_rst_n (sys_rst_n),
    .step      (step),
    .rep       (rep),
    .w         (w),
    .iw        (iw),
    .next_addr (next_addr)
  );

endmodule

`default_nettype wire

// File: source/mic_addr_latch.sv
`timescale 1ns/1ns
`default_nettype none

module mic_addr_latch (
  input  wire                        sysclk,
  input  wire                        sys_rst_n,
  input  wire                        step,       // advance strobe.
  input  wire mic_types_pkg::maddr_t rep,        // selected next fetch address.
  output mic_types_pkg::maddr_t      w,          // fetch address.
  output mic_types_pkg::maddr_t      iw,         // executing address.
  output mic_types_pkg::maddr_t      next_addr   // sequential successor of w.
);

  import mic_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // two-stage address pipe.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      w  <= '0;
      iw <= '0;
    end else if (step) begin
      iw <= w;    // the fetched word becomes the executing one.
      w  <= rep;  // and the selected address is fetched next.
    end
  end

  // rolls over from 1FFF to 0 in 13 bits.
  assign next_addr = w + maddr_t'(1);

endmodule

`default_nettype wire

// File: source/mic_addr_select.sv
`timescale 1ns/1ns
`default_nettype none

module mic_addr_select (
  input  wire                        sysclk,
  input  wire                        sys_rst_n,
  mic_ctrl_if.exec_mp                ctrl,
  input  wire mic_types_pkg::jmp_t   jmp,          // dispatch field.
  input  wire mic_types_pkg::maddr_t next_addr,    // w plus one.
  input  wire mic_types_pkg::maddr_t iw,           // executing address.
  output mic_types_pkg::maddr_t      rep,          // address to load into w.
  output logic                       stack_empty,
  output logic                       stack_full,
  output logic                       stack_err
);

  import mic_types_pkg::*;
  import mic_ucode_pkg::*;

  maddr_t jump_addr;  // jump field with the dispatch bits underneath.
  maddr_t ret_addr;   // top of the return stack.
  logic   push_req;   // call request of this step.
  logic   pop_req;    // return request of this step.

  assign jump_addr = {ctrl.jump_hi, jmp};

  // only a request on a step counts as refused, idle cycles are not faults.
  assign push_req = ctrl.push_req && ctrl.step;
  assign pop_req  = ctrl.pop_req && ctrl.step;

  //////////////////////////////////////////////////////////////////////
  // four-way source multiplexer.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.sel)
      sel_jump:   rep = jump_addr;  // plain jump or call.
      sel_return: rep = ret_addr;   // back to the instruction after the call.
      sel_next:   rep = next_addr;  // sequential flow.
      sel_repeat: rep = iw;         // run the current microinstruction again.
      default:    rep = next_addr;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // return stack, pushed with the address after the call.
  //////////////////////////////////////////////////////////////////////

  mic_return_stack return_stack_i (
    .sysclk    (sysclk),
    .sys_rst_n (sys_rst_n),
    .push      (ctrl.push),
    .pop       (ctrl.pop),
    .push_req  (push_req),
    .pop_req   (pop_req),
    .push_addr (next_addr),
    .top       (ret_addr),
    .empty     (stack_empty),
    .full      (stack_full),
    .err       (stack_err)
  );

endmodule

`default_nettype wire

// File: source/mic_return_stack.sv
`timescale 1ns/1ns
`default_nettype none

module mic_return_stack (
  input  wire                        sysclk,
  input  wire                        sys_rst_n,
  input  wire                        push,       // accepted call.
  input  wire                        pop,        // accepted return.
  input  wire                        push_req,   // call asked for on this step.
  input  wire                        pop_req,    // return asked for on this step.
  input  wire mic_types_pkg::maddr_t push_addr,  // return address to save.
  output mic_types_pkg::maddr_t      top,        // most recent return address.
  output logic                       empty,
  output logic                       full,
  output logic                       err         // sticky overflow or underflow.
);

  import mic_types_pkg::*;
  import mic_ucode_pkg::*;

  maddr_t stack_mem [stack_depth];  // return addresses, entry 0 is the oldest.
  sp_t    sp;                       // number of entries in use.
  sp_t    sp_dec;                   // sp minus one, points at the top entry.
  logic   do_push;                  // push that really writes.
  logic   do_pop;                   // pop that really removes.

  assign empty  = (sp == '0);
  assign full   = (sp == sp_t'(stack_depth));
  assign sp_dec = sp - sp_t'(1);

  assign do_push = push && !full;   // the decoder already holds these back,
  assign do_pop  = pop && !empty;   // the stack still guards its own pointer.

  // with an empty stack this reads a stale entry, the decoder never selects it then.
  assign top = stack_mem[sp_dec[sp_idx_w-1:0]];

  //////////////////////////////////////////////////////////////////////
  // storage and pointer.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sysclk) begin
    if (do_push) begin
      stack_mem[sp[sp_idx_w-1:0]] <= push_addr;  // write above the current top.
    end
  end

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      sp <= '0;
    end else if (do_push) begin
      sp <= sp + sp_t'(1);
    end else if (do_pop) begin
      sp <= sp_dec;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // error flag, set when a request was turned down.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sysclk) begin
    if (!sys_rst_n) begin
      err <= 1'b0;
    end else if ((push_req && !push) || (pop_req && !pop)) begin
      err <= 1'b1;  // stays set until the next reset.
    end
  end

endmodule

`default_nettype wire

// File: source/mic_word_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mic_word_decode (
  input  wire mic_types_pkg::mword_t mword,  // microword of the instruction at iw.
  input  wire                        step,   // advance strobe.
  input  wire                        stack_empty,
  input  wire                        stack_full,
  mic_ctrl_if.decode_mp              ctrl
);

  import mic_types_pkg::*;
  import mic_ucode_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // raw microword fields.
  //////////////////////////////////////////////////////////////////////

  msel_t  sel_raw;  // select code as written in the microword.
  logic   call;     // call flag.
  logic   csbit20;  // top jump address bit.
  csbit_t csbit;    // control-store address field.
  logic   is_call;  // jump with the call flag set.
  logic   is_ret;   // return request.

  assign sel_raw = mword[mw_sel_hi:mw_sel_lo];
  assign call    = mword[mw_call];
  assign csbit20 = mword[mw_csbit20];
  assign csbit   = mword[mw_csbit_hi:mw_csbit_lo];

  assign is_call = (sel_raw == sel_jump) && call;  // call is ignored on other codes.
  assign is_ret  = (sel_raw == sel_return);

  //////////////////////////////////////////////////////////////////////
  // resolved control.
  //////////////////////////////////////////////////////////////////////

  // the low four csbit bits are replaced by the dispatch field downstream.
  assign ctrl.jump_hi = {csbit20, csbit[csbit_w-1:jmp_w]};

  // a return with nothing stacked just carries on in sequence.
  assign ctrl.sel = (is_ret && stack_empty) ? sel_next : sel_raw;

  assign ctrl.push = step && is_call && !stack_full;  // full stack still jumps, no push.
  assign ctrl.pop  = step && is_ret && !stack_empty;  // empty stack has nothing to pop.

  // requests before the stack checks, so a refused one can be flagged.
  assign ctrl.push_req = is_call;
  assign ctrl.pop_req  = is_ret;
  assign ctrl.step     = step;

endmodule

`default_nettype wire

// File: source/mic_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mic_ctrl_if;

  import mic_types_pkg::*;

  msel_t sel;       // resolved source select for this step.
  logic  push;      // call taken on this step, stack has room.
  logic  pop;       // return taken on this step, stack has an entry.
  jhi_t  jump_hi;   // csbit20 and csbit 11..4.
  logic  step;      // advance strobe.
  logic  push_req;  // microword asks for a call, before any stack check.
  logic  pop_req;   // microword asks for a return, before any stack check.

  // the decoder drives every control line.
  modport decode_mp (
    output sel, push, pop, jump_hi, step, push_req, pop_req
  );

  // the source selector and its stack only listen.
  modport exec_mp (
    input sel, push, pop, jump_hi, step, push_req, pop_req
  );

endinterface

`default_nettype wire

// File: source/mic_ucode_pkg.sv
`default_nettype none

package mic_ucode_pkg;

  import mic_types_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // source select codes, as the SC6/SC5 pair of the microword.
  //////////////////////////////////////////////////////////////////////

  localparam msel_t sel_jump   = msel_t'(0);  // jump field plus dispatch bits.
  localparam msel_t sel_return = msel_t'(1);  // top of the return stack.
  localparam msel_t sel_next   = msel_t'(2);  // w plus one.
  localparam msel_t sel_repeat = msel_t'(3);  // re-run the executing address.

  //////////////////////////////////////////////////////////////////////
  // field positions in the microword.
  //////////////////////////////////////////////////////////////////////

  localparam int mw_sel_hi   = 15;  // upper select bit.
  localparam int mw_sel_lo   = 14;  // lower select bit.
  localparam int mw_call     = 13;  // call flag, only meaningful with a jump.
  localparam int mw_csbit20  = 12;  // top bit of the jump address.
  localparam int mw_csbit_hi = 11;  // csbit field, upper end.
  localparam int mw_csbit_lo = 0;   // csbit field, lower end.

  //////////////////////////////////////////////////////////////////////
  // return stack.
  //////////////////////////////////////////////////////////////////////

  localparam int stack_depth = 4;                     // nesting level of calls.
  localparam int sp_idx_w    = $clog2(stack_depth);   // bits to address one entry.

  // the pointer counts entries in use, so it must hold stack_depth itself.
  typedef logic [$clog2(stack_depth+1)-1:0] sp_t;

endpackage

`default_nettype wire

// File: source/mic_types_pkg.sv
`default_nettype none

package mic_types_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths of the sequencer datapath.
  //////////////////////////////////////////////////////////////////////

  localparam int maddr_w = 13;  // microaddress width, 8k words of control store.
  localparam int csbit_w = 12;  // control-store address field in the microword.
  localparam int jmp_w   = 4;   // dispatch field from the condition logic.
  localparam int mword_w = 16;  // microword bits seen by the sequencer.
  localparam int msel_w  = 2;   // four address sources.

  // the jump address is the upper field followed by the dispatch bits.
  localparam int jhi_w   = maddr_w - jmp_w;

  //////////////////////////////////////////////////////////////////////
  // vector types.
  //////////////////////////////////////////////////////////////////////

  typedef logic [maddr_w-1:0] maddr_t;  // one microaddress.
  typedef logic [csbit_w-1:0] csbit_t;  // csbit 11..0 of the microword.
  typedef logic [jmp_w-1:0]   jmp_t;    // dispatch bits, low end of a jump.
  typedef logic [mword_w-1:0] mword_t;  // sequencer part of the microword.
  typedef logic [msel_w-1:0]  msel_t;   // next address source select.
  typedef logic [jhi_w-1:0]   jhi_t;    // csbit20 and csbit 11..4.

endpackage

`default_nettype wire
